// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // address and pc width
    localparam int xlen = 32;

    // cache line geometry
    localparam int line_bytes  = 8;
    localparam int offset_bits = $clog2(line_bytes);   // byte offset, address bits 2:0

    // the cache tags only the low 64 KB of the address space
    localparam int addr_bits = 16;

    typedef logic [8*line_bytes-1:0] line_t;   // one cache line
    typedef logic [31:0]             inst_t;   // one instruction word

    // split-transaction bus tag, zero means no transaction or refused
    typedef logic [3:0] mem_tag_t;

    localparam mem_tag_t no_tag = '0;

    typedef enum logic [1:0] {
        bus_none = 2'b00,
        bus_load = 2'b01
    } bus_command_t;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

endpackage

`default_nettype wire

// File: icache/icache.sv
`timescale 1ns/10ps
`default_nettype none

module icache
    import fetch_pkg::*;
#(
    parameter int cache_lines = 32
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            squash,

    input  logic [xlen-1:0] fetch_addr,
    output line_t           line,        // memory at fetch_addr, offset cleared
    output logic            line_valid,  // ... while this is high

    output bus_command_t    mem_command,
    output logic [xlen-1:0] mem_addr,
    input  mem_tag_t        mem_response,
    input  line_t           mem_data,
    input  mem_tag_t        mem_tag
);

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits   = addr_bits - offset_bits - index_bits;

    generate
        if (cache_lines < 2 || (cache_lines & (cache_lines - 1)) != 0) begin : g_bad_lines
            $error("icache: cache_lines must be a power of two, got %0d", cache_lines);
        end
    endgenerate

    // address split of the current fetch
    logic [index_bits-1:0] current_index;
    logic [tag_bits-1:0]   current_tag;

    // address seen in the previous cycle
    logic [index_bits-1:0] last_index;
    logic [tag_bits-1:0]   last_tag;

    mem_tag_t current_mem_tag;   // tag of the load in flight or zero
    logic     miss_outstanding;  // request still needs a tag from memory

    logic changed_addr;
    logic data_write_enable;
    logic unanswered_miss;
    logic fill;

    // cache storage
    line_t                  data [cache_lines];
    logic [tag_bits-1:0]    tags [cache_lines];
    logic [cache_lines-1:0] valids;

    assign current_index = fetch_addr[offset_bits +: index_bits];
    assign current_tag   = fetch_addr[addr_bits-1 -: tag_bits];

    // returning line belongs to our load
    assign data_write_enable = (current_mem_tag == mem_tag) && (current_mem_tag != no_tag);

    // a squash throws away whatever comes back in the same cycle
    assign fill = data_write_enable && !squash;

    assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

    // new address misses, or the last request got refused
    always_comb begin
        if (changed_addr) begin
            unanswered_miss = !line_valid;
        end else begin
            unanswered_miss = miss_outstanding && (mem_response == no_tag);
        end
    end

    // request goes out one cycle after the address settles
    assign mem_command = (miss_outstanding && !changed_addr) ? bus_load : bus_none;
    assign mem_addr    = {fetch_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};

    // hit path, purely combinational
    assign line       = valids[current_index] ? data[current_index] : '0;
    assign line_valid = valids[current_index] && (tags[current_index] == current_tag);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            // all ones so the next address always looks new
            last_index       <= '1;
            last_tag         <= '1;
            current_mem_tag  <= no_tag;
            miss_outstanding <= 1'b0;
        end else begin
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;

            if (miss_outstanding) begin
                current_mem_tag <= mem_response;   // zero again if refused
            end else if (changed_addr || data_write_enable) begin
                current_mem_tag <= no_tag;         // load done or abandoned
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valids <= '0;
        end else if (fill) begin
            valids[current_index] <= 1'b1;
        end
    end

    // line payload and tag
    always_ff @(posedge clock) begin
        if (fill) begin
            data[current_index] <= mem_data;
            tags[current_index] <= current_tag;
        end
    end

    // the request waits until the line address has held for a cycle
    a_no_load_on_change: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command == bus_load) |-> $stable(mem_addr[addr_bits-1:offset_bits])
    ) else $error("icache: bus_load issued while the fetch address changed");

    // a fill only answers a load that memory already granted
    a_fill_has_tag: assert property (
        @(posedge clock) disable iff (reset)
        fill |-> !miss_outstanding
    ) else $error("icache: line filled while its request was still unanswered");

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,

    // back end control
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            stall,

    // cache side
    input  line_t           line,
    input  logic            line_valid,
    output logic [xlen-1:0] fetch_addr,
    output logic            squash,

    // to decode
    output inst_t           inst,
    output logic [xlen-1:0] inst_pc,
    output logic            inst_valid
);

    localparam int inst_bits = $bits(inst_t);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;
    logic            advance;

    // redirect kills any miss in flight
    assign squash = redirect && !reset;

    assign fetch_addr = pc;

    // instruction being fetched is dropped on a redirect
    assign inst_valid = line_valid && !redirect;
    assign advance    = inst_valid && !stall;

    // little-endian word order, pc bit 2 picks the upper word
    assign inst    = pc[2] ? line[inst_bits +: inst_bits] : line[0 +: inst_bits];
    assign inst_pc = pc;

    always_comb begin
        next_pc = pc;   // hold on stall or miss
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (advance) begin
            next_pc = pc + xlen'(4);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("fetch_stage: pc %h not word aligned", pc);

    // a stalled valid instruction must not move, including the cache line behind it
    a_stall_holds: assert property (
        @(posedge clock) disable iff (reset)
        (stall && inst_valid) |=> ($stable(inst_pc) && $stable(inst))
    ) else $error("fetch_stage: instruction changed under stall");

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int cache_lines = 32
) (
    input  logic            clock,
    input  logic            reset,

    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            stall,

    output inst_t           inst,
    output logic [xlen-1:0] inst_pc,
    output logic            inst_valid,

    // split-transaction memory bus
    output bus_command_t    mem_command,
    output logic [xlen-1:0] mem_addr,
    input  mem_tag_t        mem_response,
    input  line_t           mem_data,
    input  mem_tag_t        mem_tag
);

    logic [xlen-1:0] fetch_addr;
    logic            squash;
    line_t           line;
    logic            line_valid;

    fetch_stage u_fetch_stage (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .line        (line),
        .line_valid  (line_valid),
        .fetch_addr  (fetch_addr),
        .squash      (squash),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid)
    );

    icache #(
        .cache_lines (cache_lines)
    ) u_icache (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .fetch_addr   (fetch_addr),
        .line         (line),
        .line_valid   (line_valid),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

endmodule

`default_nettype wire

// File: tb/tagged_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tagged_mem
    import fetch_pkg::*;
#(
    parameter int          mem_latency   = 6,
    parameter int          refuse_one_in = 4,
    parameter logic [31:0] fill_key      = 32'h0000_0000
) (
    input  logic            clock,
    input  bus_command_t    mem_command,
    input  logic [xlen-1:0] mem_addr,
    output mem_tag_t        mem_response,
    output line_t           mem_data,
    output mem_tag_t        mem_tag
);

    // loads in flight, oldest first
    int unsigned     due_cycle [$];
    mem_tag_t        due_tag   [$];
    logic [xlen-1:0] due_addr  [$];

    // word at address a holds a ^ fill_key, lower address in the low half
    function automatic line_t line_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] base;
        base = {addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
        return {(base + xlen'(4)) ^ fill_key, base ^ fill_key};
    endfunction

    // outputs change on the falling edge only
    initial begin
        int unsigned cycle;
        mem_tag_t    next_tag;
        cycle        = 0;
        next_tag     = 4'd1;
        mem_response = no_tag;
        mem_data     = '0;
        mem_tag      = no_tag;
        forever begin
            @(negedge clock);
            cycle++;
            mem_response = no_tag;
            mem_tag      = no_tag;
            mem_data     = '0;

            // at most one return per cycle
            if (due_cycle.size() > 0 && due_cycle[0] <= cycle) begin
                void'(due_cycle.pop_front());
                mem_tag  = due_tag.pop_front();
                mem_data = line_at(due_addr.pop_front());
            end

            if (mem_command == bus_load) begin
                if (($urandom % refuse_one_in) != 0) begin
                    mem_response = next_tag;
                    due_cycle.push_back(cycle + mem_latency);
                    due_tag.push_back(next_tag);
                    due_addr.push_back(mem_addr);
                    // rotate through 1..15, zero is reserved
                    next_tag = (next_tag == 4'hf) ? 4'd1 : next_tag + 4'd1;
                end
                // else refused, the cache asks again
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int cache_lines   = 32;
    localparam int mem_latency   = 6;
    localparam int refuse_one_in = 4;
    localparam int reset_cycles  = 5;

    localparam logic [31:0] inst_key    = 32'h5a3c_96e1;
    localparam logic [31:0] random_seed = 32'h56a5_0e47;

    // instructions per test
    localparam int cold_count      = 64;
    localparam int loop_count      = 64;
    localparam int squash_rounds   = 3;
    localparam int squash_count    = 6;
    localparam int conflict_rounds = 4;
    localparam int conflict_count  = 4;
    localparam int stall_count     = 32;
    localparam int refused_count   = 48;
    localparam int total_insts = cold_count + loop_count + squash_rounds * squash_count
                               + conflict_rounds * conflict_count + stall_count + refused_count;
    localparam int timeout_cycles = total_insts * (mem_latency + 8);

    // same index with a different tag
    localparam logic [xlen-1:0] conflict_a = 32'h0000_2000;
    localparam logic [xlen-1:0] conflict_b = conflict_a + cache_lines * line_bytes;

    logic            clock;
    logic            reset;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    logic            stall;
    inst_t           inst;
    logic [xlen-1:0] inst_pc;
    logic            inst_valid;
    bus_command_t    mem_command;
    logic [xlen-1:0] mem_addr;
    mem_tag_t        mem_response;
    line_t           mem_data;
    mem_tag_t        mem_tag;

    string           test_name = "reset";
    logic [xlen-1:0] expected_pc;
    logic            held_valid = 1'b0;   // last edge had a stalled valid instruction
    logic [xlen-1:0] held_pc;
    inst_t           held_inst;
    int              accepted_count = 0;
    int              load_grants    = 0;
    int              refusal_count  = 0;
    int              cycle_count    = 0;

    fetch_top #(
        .cache_lines (cache_lines)
    ) u_dut (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .stall        (stall),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_valid   (inst_valid),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

    tagged_mem #(
        .mem_latency   (mem_latency),
        .refuse_one_in (refuse_one_in),
        .fill_key      (inst_key)
    ) u_mem (
        .clock        (clock),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic inst_t expected_inst(input logic [xlen-1:0] addr);
        return inst_t'(addr ^ inst_key);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pc(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s pc: expected %h actual %h",
                                     test_name, expected, actual));
        end
    endtask

    task automatic check_inst(input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s inst: expected %h actual %h",
                                     test_name, expected, actual));
        end
    endtask

    task automatic check_line_addr(input logic [xlen-1:0] expected,
                                   input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s mem_addr: expected %h actual %h",
                                     test_name, expected, actual));
        end
    endtask

    task automatic check_load_count(input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("MISMATCH %s line loads: expected %0d actual %0d",
                                     test_name, expected, actual));
        end
    endtask

    // reference model of the fetch stream
    always @(posedge clock) begin
        if (reset) begin
            expected_pc = reset_pc;
            held_valid  = 1'b0;
        end else begin
            if (held_valid && !redirect) begin
                if (!inst_valid) begin
                    report_failure($sformatf("%s: inst_valid dropped while stalled", test_name));
                end
                check_pc(held_pc, inst_pc);
                check_inst(held_inst, inst);
            end
            if (inst_valid) begin
                check_pc(expected_pc, inst_pc);
                check_inst(expected_inst(expected_pc), inst);
            end
            // a load always asks for the line of the pc being fetched
            if (mem_command == bus_load) begin
                check_line_addr({expected_pc[xlen-1:offset_bits], {offset_bits{1'b0}}},
                                mem_addr);
            end
            held_valid = inst_valid && stall;
            held_pc    = inst_pc;
            held_inst  = inst;

            if (redirect) begin
                expected_pc = redirect_pc;
            end else if (inst_valid && !stall) begin
                expected_pc    = expected_pc + xlen'(4);
                accepted_count = accepted_count + 1;
            end

            if (mem_command == bus_load) begin
                if (mem_response == no_tag) begin
                    refusal_count = refusal_count + 1;
                end else begin
                    load_grants = load_grants + 1;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("fetch hung in %s, no finish after %0d cycles",
                                     test_name, cycle_count));
        end
    end

    // stimulus tasks start and end on a falling edge
    task automatic redirect_to(input logic [xlen-1:0] target);
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clock);
        redirect    = 1'b0;
    endtask

    task automatic wait_accepted(input int count);
        int target;
        target = accepted_count + count;
        while (accepted_count < target) @(negedge clock);
    endtask

    task automatic run_with_stalls(input int count);
        int target;
        target = accepted_count + count;
        while (accepted_count < target) begin
            if ($urandom % 3 == 0) begin
                stall = 1'b1;
                repeat (1 + $urandom % 4) @(negedge clock);
                stall = 1'b0;
            end
            @(negedge clock);
        end
    endtask

    initial begin
        int grants_before;
        void'($urandom(random_seed));
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;

        // one load per line and the second word hits
        test_name     = "cold_sequential";
        grants_before = load_grants;
        wait_accepted(cold_count);
        check_load_count(cold_count / 2, load_grants - grants_before);

        test_name     = "loop_reuse";
        grants_before = load_grants;
        redirect_to(reset_pc);
        wait_accepted(loop_count);
        check_load_count(0, load_grants - grants_before);

        test_name = "squash_miss";
        for (int round = 0; round < squash_rounds; round++) begin
            redirect_to(32'h0000_3000 + round * 'h40);
            while (mem_command != bus_load) @(negedge clock);
            repeat (1 + round) @(negedge clock);   // deeper into the wait each round
            if (inst_valid) begin
                report_failure("squash_miss: abandoned address did not miss");
            end
            redirect_to(32'h0000_4000 + round * 'h40);
            wait_accepted(squash_count);
        end

        test_name = "conflict";
        for (int round = 0; round < conflict_rounds; round++) begin
            redirect_to(round[0] ? conflict_b : conflict_a);
            wait_accepted(conflict_count);
        end

        // mix of cached lines and lines evicted above
        test_name = "stall";
        redirect_to(reset_pc + 'h80);
        run_with_stalls(stall_count);

        test_name = "refused";
        redirect_to(32'h0000_6000);
        wait_accepted(refused_count);

        if (refusal_count > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure("memory never refused a request so retries were not exercised");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
common/fetch_pkg.sv
icache/icache.sv
src/fetch_stage.sv
src/fetch_top.sv
tb/tagged_mem.sv
tb/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - common/fetch_pkg.sv
      - icache/icache.sv
      - src/fetch_stage.sv
      - src/fetch_top.sv

  - target: test
    files:
      - tb/tagged_mem.sv
      - tb/tb_fetch_top.sv
